// ==== source/motor_pkg.sv ====
`default_nettype none

package motor_pkg;

	localparam int STEP_W = 16;
	localparam int SPEED_W = 16;

	// ramp shape, A(i) = RAMP_BASE - RAMP_SLOPE * min(i, RAMP_LEN-1)
	localparam int RAMP_LEN = 16;
	localparam int RAMP_ADDR_W = 4;
	localparam logic [SPEED_W-1:0] RAMP_BASE = SPEED_W'(200);
	localparam logic [SPEED_W-1:0] RAMP_SLOPE = SPEED_W'(12);

	// idle clocks before stepping the other way
	localparam logic [3:0] REVERSE_DELAY = 4'd8;

	localparam int QUEUE_LEVEL_W = 3;
	localparam logic [QUEUE_LEVEL_W-1:0] QUEUE_DEPTH = QUEUE_LEVEL_W'(4);

	typedef struct packed {
		logic [SPEED_W-1:0] speed;
		logic [STEP_W-1:0] steps;
		logic dir;
	} move_cmd_t;

	typedef struct packed {
		logic busy;
		logic [QUEUE_LEVEL_W-1:0] level;
		logic [11:0] done_cnt;
	} motor_status_t;

endpackage

`default_nettype wire

// ==== source/axil_pkg.sv ====
`default_nettype none

package axil_pkg;

	localparam int ADDR_W = 4;
	localparam int DATA_W = 32;

	localparam logic [ADDR_W-1:0] REG_SPEED = 4'h0;
	localparam logic [ADDR_W-1:0] REG_MOVE = 4'h4;
	localparam logic [ADDR_W-1:0] REG_CTRL = 4'h8;
	localparam logic [ADDR_W-1:0] REG_STATUS = 4'hC;

	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic valid;
	} axil_aw_t;

	typedef struct packed {
		logic [DATA_W-1:0] data;
		logic [DATA_W/8-1:0] strb;
		logic valid;
	} axil_w_t;

	typedef struct packed {
		logic [1:0] resp;
		logic valid;
	} axil_b_t;

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic valid;
	} axil_ar_t;

	typedef struct packed {
		logic [DATA_W-1:0] data;
		logic [1:0] resp;
		logic valid;
	} axil_r_t;

endpackage

`default_nettype wire

// ==== source/motor_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module motor_regs (
	input  wire clk,
	input  wire resetn,
	input  wire axil_pkg::axil_aw_t i_aw,
	input  wire axil_pkg::axil_w_t i_w,
	input  wire axil_pkg::axil_ar_t i_ar,
	input  wire i_bready,
	input  wire i_rready,
	input  wire motor_pkg::motor_status_t i_status,
	input  wire [motor_pkg::QUEUE_LEVEL_W-1:0] i_queue_level,
	output logic o_awready,
	output logic o_wready,
	output logic o_arready,
	output axil_pkg::axil_b_t o_b,
	output axil_pkg::axil_r_t o_r,
	output logic o_push,
	output motor_pkg::move_cmd_t o_cmd,
	output logic o_stop
);
	logic wr_fire;
	logic rd_fire;
	logic queue_full;
	logic [1:0] wr_resp;
	logic b_valid;
	logic [1:0] b_resp;
	logic r_valid;
	logic [1:0] r_resp;
	logic [axil_pkg::DATA_W-1:0] r_data;
	logic [motor_pkg::SPEED_W-1:0] speed_reg;
	logic [motor_pkg::STEP_W:0] move_reg;

	// aw and w taken together, one write in flight
	assign wr_fire = i_aw.valid && i_w.valid && !b_valid;
	assign o_awready = wr_fire;
	assign o_wready = wr_fire;
	assign rd_fire = i_ar.valid && !r_valid;
	assign o_arready = !r_valid;
	assign queue_full = (i_queue_level == motor_pkg::QUEUE_DEPTH);

	always_comb begin
		wr_resp = axil_pkg::RESP_OKAY;
		case (i_aw.addr)
		axil_pkg::REG_SPEED, axil_pkg::REG_CTRL: wr_resp = axil_pkg::RESP_OKAY;
		axil_pkg::REG_MOVE: if (queue_full) wr_resp = axil_pkg::RESP_SLVERR;
		default: wr_resp = axil_pkg::RESP_SLVERR;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			b_valid <= 1'b0;
			r_valid <= 1'b0;
			o_push <= 1'b0;
			o_stop <= 1'b0;
			speed_reg <= '0;
			move_reg <= '0;
		end else begin
			o_push <= 1'b0;
			o_stop <= 1'b0;
			if (wr_fire) begin
				b_valid <= 1'b1;
				case (i_aw.addr)
				axil_pkg::REG_SPEED: begin
					if (i_w.strb[0])
						speed_reg[7:0] <= i_w.data[7:0];
					if (i_w.strb[1])
						speed_reg[15:8] <= i_w.data[15:8];
				end
				axil_pkg::REG_MOVE: begin
					if (!queue_full) begin
						o_push <= 1'b1;
						move_reg <= i_w.data[motor_pkg::STEP_W:0];
					end
				end
				axil_pkg::REG_CTRL: o_stop <= i_w.data[0];
				default: ;
				endcase
			end else if (i_bready) begin
				b_valid <= 1'b0;
			end
			if (rd_fire)
				r_valid <= 1'b1;
			else if (i_rready)
				r_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_fire) begin
			b_resp <= wr_resp;
			o_cmd.speed <= speed_reg;
			o_cmd.steps <= i_w.data[motor_pkg::STEP_W-1:0];
			o_cmd.dir <= i_w.data[motor_pkg::STEP_W];
		end
		if (rd_fire) begin
			r_resp <= axil_pkg::RESP_OKAY;
			case (i_ar.addr)
			axil_pkg::REG_SPEED:
				r_data <= {{(axil_pkg::DATA_W-motor_pkg::SPEED_W){1'b0}}, speed_reg};
			axil_pkg::REG_MOVE:
				r_data <= {{(axil_pkg::DATA_W-motor_pkg::STEP_W-1){1'b0}}, move_reg};
			axil_pkg::REG_CTRL: r_data <= '0;
			axil_pkg::REG_STATUS: r_data <= {{(axil_pkg::DATA_W-
				$bits(motor_pkg::motor_status_t)){1'b0}}, i_status};
			default: begin
				r_data <= '0;
				r_resp <= axil_pkg::RESP_SLVERR;
			end
			endcase
		end
	end

	always_comb begin
		o_b.resp = b_resp;
		o_b.valid = b_valid;
		o_r.data = r_data;
		o_r.resp = r_resp;
		o_r.valid = r_valid;
	end

	// full is judged at the handshake, the push lands a cycle later
	assert property (@(posedge clk) disable iff (!resetn)
		o_push |-> i_queue_level != motor_pkg::QUEUE_DEPTH)
		else $error("move pushed into a full queue");

endmodule

`default_nettype wire

// ==== source/cmd_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module cmd_queue (
	input  wire clk,
	input  wire resetn,
	input  wire i_push,
	input  wire motor_pkg::move_cmd_t i_cmd,
	input  wire i_pop,
	input  wire i_flush,
	output motor_pkg::move_cmd_t o_head,
	output logic o_not_empty,
	output logic [motor_pkg::QUEUE_LEVEL_W-1:0] o_level
);
	motor_pkg::move_cmd_t mem [motor_pkg::QUEUE_DEPTH];
	logic [motor_pkg::QUEUE_LEVEL_W-2:0] wr_ptr;
	logic [motor_pkg::QUEUE_LEVEL_W-2:0] rd_ptr;
	logic [motor_pkg::QUEUE_LEVEL_W-1:0] count;
	logic do_push;

	assign do_push = i_push && (count != motor_pkg::QUEUE_DEPTH);

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= i_cmd;
	end

	// pointers wrap by width, depth is a power of two
	always_ff @(posedge clk) begin
		if (!resetn || i_flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (i_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, i_pop})
			2'b10: count <= count + 1'b1;
			2'b01: count <= count - 1'b1;
			default: ;
			endcase
		end
	end

	assign o_head = mem[rd_ptr];
	assign o_not_empty = (count != '0);
	assign o_level = count;

	assert property (@(posedge clk) disable iff (!resetn) i_pop |-> count != '0)
		else $error("pop from an empty command queue");

endmodule

`default_nettype wire

// ==== source/speed_profile.sv ====
`timescale 1ns/1ps
`default_nettype none

module speed_profile (
	input  wire clk,
	input  wire [motor_pkg::RAMP_ADDR_W-1:0] i_acc_addr,
	input  wire [motor_pkg::RAMP_ADDR_W-1:0] i_dec_addr,
	output logic [motor_pkg::SPEED_W-1:0] o_acc_period,
	output logic [motor_pkg::SPEED_W-1:0] o_dec_period
);
	logic [motor_pkg::SPEED_W-1:0] ramp_rom [motor_pkg::RAMP_LEN];

	// constant table, half-period shrinks by one slope per entry
	always_comb begin
		for (int i = 0; i < motor_pkg::RAMP_LEN; i++) begin
			ramp_rom[i[motor_pkg::RAMP_ADDR_W-1:0]] = motor_pkg::RAMP_BASE -
				motor_pkg::RAMP_SLOPE * i[motor_pkg::SPEED_W-1:0];
		end
	end

	// decel side reads the same ramp, indexed by steps left
	always_ff @(posedge clk) begin
		o_acc_period <= ramp_rom[i_acc_addr];
		o_dec_period <= ramp_rom[i_dec_addr];
	end

endmodule

`default_nettype wire

// ==== source/step_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module step_engine (
	input  wire clk,
	input  wire resetn,
	input  wire motor_pkg::move_cmd_t i_cmd,
	input  wire i_cmd_valid,
	input  wire i_stop,
	input  wire [motor_pkg::SPEED_W-1:0] i_acc_period,
	input  wire [motor_pkg::SPEED_W-1:0] i_dec_period,
	input  wire [motor_pkg::QUEUE_LEVEL_W-1:0] i_queue_level,
	output logic o_pop,
	output logic [motor_pkg::RAMP_ADDR_W-1:0] o_acc_addr,
	output logic [motor_pkg::RAMP_ADDR_W-1:0] o_dec_addr,
	output logic o_drive,
	output logic o_dir,
	output motor_pkg::motor_status_t o_status
);
	typedef enum logic [1:0] {IDLE, PREPARE, RUNNING} state_t;

	state_t state;
	logic take;
	logic [motor_pkg::STEP_W-1:0] step_cnt;
	logic [motor_pkg::STEP_W-1:0] step_remain;
	logic step_done;
	logic [$bits(motor_pkg::REVERSE_DELAY)-1:0] prep_cnt;
	logic [motor_pkg::SPEED_W-1:0] speed_max;
	logic [motor_pkg::SPEED_W-1:0] ramp_max;
	logic [motor_pkg::SPEED_W-1:0] period;
	logic [motor_pkg::SPEED_W-1:0] half_cnt;
	logic [11:0] done_cnt;

	assign take = (state == IDLE) && i_cmd_valid && !i_stop;
	assign o_pop = take;

	// table index saturates at the last entry
	assign o_acc_addr = (|step_cnt[motor_pkg::STEP_W-1:motor_pkg::RAMP_ADDR_W]) ?
		'1 : step_cnt[motor_pkg::RAMP_ADDR_W-1:0];
	assign o_dec_addr = (|step_remain[motor_pkg::STEP_W-1:motor_pkg::RAMP_ADDR_W]) ?
		'1 : step_remain[motor_pkg::RAMP_ADDR_W-1:0];

	// slowest of accel, decel and cruise wins
	assign ramp_max = (i_acc_period > i_dec_period) ? i_acc_period : i_dec_period;

	always_ff @(posedge clk) begin
		if (take)
			speed_max <= i_cmd.speed;
		period <= (ramp_max > speed_max) ? ramp_max : speed_max;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= IDLE;
			prep_cnt <= '0;
			step_cnt <= '0;
			step_remain <= '0;
			step_done <= 1'b0;
			half_cnt <= '0;
			done_cnt <= '0;
			o_drive <= 1'b0;
			o_dir <= 1'b0;
		end else if (i_stop) begin
			// aborted move is not counted
			state <= IDLE;
			o_drive <= 1'b0;
		end else begin
			case (state)
			IDLE: begin
				// zero-step moves are popped and dropped
				if (take && i_cmd.steps != '0) begin
					state <= PREPARE;
					prep_cnt <= (i_cmd.dir != o_dir) ?
						motor_pkg::REVERSE_DELAY - 1'b1 : '0;
					o_dir <= i_cmd.dir;
					step_cnt <= '0;
					step_remain <= i_cmd.steps - 1'b1;
					step_done <= 1'b0;
				end
			end
			PREPARE: begin
				// two clocks for table read and max stage
				half_cnt <= {{(motor_pkg::SPEED_W-1){1'b0}}, 1'b1};
				if (prep_cnt == '0)
					state <= RUNNING;
				else
					prep_cnt <= prep_cnt - 1'b1;
			end
			RUNNING: begin
				if (half_cnt != '0) begin
					half_cnt <= half_cnt - 1'b1;
				end else if (step_done) begin
					state <= IDLE;
					done_cnt <= done_cnt + 1'b1;
				end else begin
					o_drive <= ~o_drive;
					half_cnt <= period;
					// falling edge closes step k
					if (o_drive) begin
						if (step_remain == '0) begin
							step_done <= 1'b1;
						end else begin
							step_cnt <= step_cnt + 1'b1;
							step_remain <= step_remain - 1'b1;
						end
					end
				end
			end
			default: state <= IDLE;
			endcase
		end
	end

	always_comb begin
		o_status.busy = (state != IDLE);
		o_status.level = i_queue_level;
		o_status.done_cnt = done_cnt;
	end

	assert property (@(posedge clk) disable iff (!resetn) (state != RUNNING) |-> !o_drive)
		else $error("drive high outside RUNNING");

endmodule

`default_nettype wire

// ==== source/motor_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module motor_top (
	input  wire clk,
	input  wire resetn,
	input  wire axil_pkg::axil_aw_t i_aw,
	input  wire axil_pkg::axil_w_t i_w,
	input  wire axil_pkg::axil_ar_t i_ar,
	input  wire i_bready,
	input  wire i_rready,
	output logic o_awready,
	output logic o_wready,
	output logic o_arready,
	output axil_pkg::axil_b_t o_b,
	output axil_pkg::axil_r_t o_r,
	output logic o_drive,
	output logic o_dir
);
	logic push;
	logic pop;
	logic stop;
	logic not_empty;
	motor_pkg::move_cmd_t push_cmd;
	motor_pkg::move_cmd_t head_cmd;
	motor_pkg::motor_status_t status;
	logic [motor_pkg::QUEUE_LEVEL_W-1:0] level;
	logic [motor_pkg::RAMP_ADDR_W-1:0] acc_addr;
	logic [motor_pkg::RAMP_ADDR_W-1:0] dec_addr;
	logic [motor_pkg::SPEED_W-1:0] acc_period;
	logic [motor_pkg::SPEED_W-1:0] dec_period;

	motor_regs motor_regs_inst (
		.clk(clk), .resetn(resetn),
		.i_aw(i_aw), .i_w(i_w), .i_ar(i_ar),
		.i_bready(i_bready), .i_rready(i_rready),
		.i_status(status), .i_queue_level(level),
		.o_awready(o_awready), .o_wready(o_wready), .o_arready(o_arready),
		.o_b(o_b), .o_r(o_r),
		.o_push(push), .o_cmd(push_cmd), .o_stop(stop)
	);

	cmd_queue cmd_queue_inst (
		.clk(clk), .resetn(resetn),
		.i_push(push), .i_cmd(push_cmd), .i_pop(pop), .i_flush(stop),
		.o_head(head_cmd), .o_not_empty(not_empty), .o_level(level)
	);

	speed_profile speed_profile_inst (
		.clk(clk),
		.i_acc_addr(acc_addr), .i_dec_addr(dec_addr),
		.o_acc_period(acc_period), .o_dec_period(dec_period)
	);

	step_engine step_engine_inst (
		.clk(clk), .resetn(resetn),
		.i_cmd(head_cmd), .i_cmd_valid(not_empty), .i_stop(stop),
		.i_acc_period(acc_period), .i_dec_period(dec_period),
		.i_queue_level(level),
		.o_pop(pop), .o_acc_addr(acc_addr), .o_dec_addr(dec_addr),
		.o_drive(o_drive), .o_dir(o_dir), .o_status(status)
	);

endmodule

`default_nettype wire

// ==== test/tb_motor_model.svh ====
`ifndef TB_MOTOR_MODEL_SVH
`define TB_MOTOR_MODEL_SVH

// moves accepted by the DUT and not yet started on o_drive
motor_pkg::move_cmd_t expected_moves[$];

// A(i), flat after the last table entry
function automatic int ramp_period(input int i);
	int idx;
	idx = (i < motor_pkg::RAMP_LEN - 1) ? i : motor_pkg::RAMP_LEN - 1;
	return int'(motor_pkg::RAMP_BASE) - int'(motor_pkg::RAMP_SLOPE) * idx;
endfunction

// P(k): slowest of cruise, ramp up and ramp down
function automatic int step_period(input motor_pkg::move_cmd_t cmd, input int k);
	int p;
	int n;
	n = int'(cmd.steps);
	p = int'(cmd.speed);
	if (ramp_period(k) > p)
		p = ramp_period(k);
	if (ramp_period(n - 1 - k) > p)
		p = ramp_period(n - 1 - k);
	return p;
endfunction

// clocks from the first rising edge to the end of the last low phase
function automatic int move_cycles(input motor_pkg::move_cmd_t cmd);
	int total;
	total = 0;
	for (int k = 0; k < int'(cmd.steps); k++)
		total += 2 * (step_period(cmd, k) + 1);
	return total;
endfunction

`endif

// ==== test/tb_motor_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_motor_top;

	typedef logic [motor_pkg::SPEED_W:0] phase_len_t;
	typedef logic [motor_pkg::SPEED_W-1:0] speed_t;
	typedef logic [motor_pkg::STEP_W-1:0] steps_t;
	typedef logic [axil_pkg::DATA_W-1:0] axil_data_t;

	logic clk;
	logic resetn;
	axil_pkg::axil_aw_t aw;
	axil_pkg::axil_w_t w;
	axil_pkg::axil_ar_t ar;
	logic bready;
	logic rready;
	logic awready;
	logic wready;
	logic arready;
	axil_pkg::axil_b_t b;
	axil_pkg::axil_r_t r;
	logic drive;
	logic dir;

	logic [31:0] rng_state;
	int cycle_limit;
	int ticks;
	int cyc;
	int moves_accepted;
	int moves_cancelled;
	logic watch;
	logic prev_drive;
	logic active;
	logic last_dir;
	int step_k;
	int rise_cyc;
	int fall_cyc;
	int move_end;
	motor_pkg::move_cmd_t cur;

	`include "tb_motor_model.svh"

	motor_top motor_top_inst (
		.clk(clk), .resetn(resetn),
		.i_aw(aw), .i_w(w), .i_ar(ar),
		.i_bready(bready), .i_rready(rready),
		.o_awready(awready), .o_wready(wready), .o_arready(arready),
		.o_b(b), .o_r(r),
		.o_drive(drive), .o_dir(dir)
	);

	always #10 clk = ~clk;

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic check_resp(input string name, input logic [1:0] exp, input logic [1:0] got);
		if (got !== exp)
			abort_run($sformatf("CHECK FAILED %s: expected 0x%h got 0x%h", name, exp, got));
	endtask

	task automatic check_ready(input string name, input logic exp, input logic got);
		if (got !== exp)
			abort_run($sformatf("CHECK FAILED %s: expected 0x%h got 0x%h", name, exp, got));
	endtask

	task automatic check_data(input string name, input axil_data_t exp, input axil_data_t got);
		if (got !== exp)
			abort_run($sformatf("CHECK FAILED %s: expected 0x%h got 0x%h", name, exp, got));
	endtask

	task automatic check_status(input motor_pkg::motor_status_t exp,
			input motor_pkg::motor_status_t got);
		if (got !== exp)
			abort_run($sformatf("CHECK FAILED status: expected 0x%h got 0x%h", exp, got));
	endtask

	task automatic check_step(input string name, input logic exp_dir, input logic got_dir,
			input phase_len_t exp_len, input phase_len_t got_len);
		if (got_dir !== exp_dir)
			abort_run($sformatf("CHECK FAILED o_dir: expected 0x%h got 0x%h", exp_dir, got_dir));
		if (got_len !== exp_len)
			abort_run($sformatf("CHECK FAILED %s: expected 0x%h got 0x%h", name, exp_len, got_len));
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic int rand_range(input int lo, input int hi);
		rng_state = xorshift32(rng_state);
		return lo + int'(rng_state % 32'(hi - lo + 1));
	endfunction

	function automatic motor_pkg::move_cmd_t random_move();
		motor_pkg::move_cmd_t cmd;
		cmd.speed = speed_t'(rand_range(0, 240));
		cmd.steps = steps_t'(rand_range(1, 40));
		cmd.dir = rand_range(0, 1) == 1;
		return cmd;
	endfunction

	// bready is held high, so B shows for one cycle after the handshake
	task automatic write_reg(input logic [axil_pkg::ADDR_W-1:0] addr, input axil_data_t data,
			output logic [1:0] resp);
		@(negedge clk);
		aw.addr = addr;
		aw.valid = 1'b1;
		w.data = data;
		w.strb = '1;
		w.valid = 1'b1;
		do
			@(negedge clk);
		while (!b.valid);
		// pending B holds off the next write
		check_ready("o_awready", 1'b0, awready);
		check_ready("o_wready", 1'b0, wready);
		resp = b.resp;
		aw.valid = 1'b0;
		w.valid = 1'b0;
	endtask

	task automatic read_reg(input logic [axil_pkg::ADDR_W-1:0] addr, output axil_data_t data,
			output logic [1:0] resp);
		@(negedge clk);
		check_ready("o_arready", 1'b1, arready);
		ar.addr = addr;
		ar.valid = 1'b1;
		do
			@(negedge clk);
		while (!r.valid);
		check_ready("o_arready", 1'b0, arready);
		data = r.data;
		resp = r.resp;
		ar.valid = 1'b0;
	endtask

	task automatic send_move(input motor_pkg::move_cmd_t cmd, input logic expect_ok);
		logic [1:0] resp;
		axil_data_t rdata;
		write_reg(axil_pkg::REG_SPEED, axil_data_t'(cmd.speed), resp);
		check_resp("o_b.resp speed", axil_pkg::RESP_OKAY, resp);
		read_reg(axil_pkg::REG_SPEED, rdata, resp);
		check_resp("o_r.resp speed", axil_pkg::RESP_OKAY, resp);
		check_data("o_r.data speed", axil_data_t'(cmd.speed), rdata);
		if (expect_ok) begin
			expected_moves.push_back(cmd);
			moves_accepted++;
			cycle_limit += move_cycles(cmd) + 40;
		end
		write_reg(axil_pkg::REG_MOVE, axil_data_t'({cmd.dir, cmd.steps}), resp);
		check_resp("o_b.resp move", expect_ok ? axil_pkg::RESP_OKAY : axil_pkg::RESP_SLVERR,
			resp);
	endtask

	// poll STATUS until busy drops and compare it with the model
	task automatic check_idle_status();
		logic [1:0] resp;
		axil_data_t rdata;
		motor_pkg::motor_status_t st;
		motor_pkg::motor_status_t exp;
		do begin
			read_reg(axil_pkg::REG_STATUS, rdata, resp);
			check_resp("o_r.resp status", axil_pkg::RESP_OKAY, resp);
			st = rdata[$bits(motor_pkg::motor_status_t)-1:0];
		end while (st.busy);
		exp.busy = 1'b0;
		exp.level = '0;
		exp.done_cnt = 12'(moves_accepted - moves_cancelled);
		check_status(exp, st);
	endtask

	task automatic wait_idle();
		do
			@(posedge clk);
		while (active || expected_moves.size() != 0);
		check_idle_status();
	endtask

	task automatic random_batches(input int count);
		int n;
		for (int i = 0; i < count; i++) begin
			n = rand_range(1, 4);
			for (int j = 0; j < n; j++)
				send_move(random_move(), 1'b1);
			wait_idle();
		end
	endtask

	// pulse monitor counts phases in falling-edge samples
	always @(negedge clk) begin
		cyc = cyc + 1;
		if (watch && drive && !prev_drive) begin
			if (!active) begin
				if (expected_moves.size() == 0)
					abort_run("o_drive rose while no move was expected");
				cur = expected_moves.pop_front();
				active = 1'b1;
				step_k = 0;
				// gap counted from the end of the last low phase of the previous move
				if (cyc - move_end < 1)
					abort_run("o_drive rose before the previous move had ended");
				if (cur.dir != last_dir && cyc - move_end < int'(motor_pkg::REVERSE_DELAY))
					abort_run("stepping resumed in the new direction before the reverse delay");
			end else begin
				check_step("o_drive low phase", cur.dir, dir,
					phase_len_t'(step_period(cur, step_k) + 1), phase_len_t'(cyc - fall_cyc));
				step_k++;
			end
			rise_cyc = cyc;
		end else if (!drive && prev_drive) begin
			if (watch && active) begin
				check_step("o_drive high phase", cur.dir, dir,
					phase_len_t'(step_period(cur, step_k) + 1), phase_len_t'(cyc - rise_cyc));
				if (step_k == int'(cur.steps) - 1) begin
					active = 1'b0;
					last_dir = cur.dir;
					move_end = cyc + step_period(cur, step_k) + 1;
				end
			end
			fall_cyc = cyc;
		end
		prev_drive = drive;
	end

	always @(posedge clk) begin
		ticks = ticks + 1;
		if (ticks > cycle_limit)
			abort_run($sformatf("timeout: run went past its budget of %0d clocks", cycle_limit));
	end

	initial begin
		logic [1:0] resp;
		motor_pkg::move_cmd_t cmd;
		clk = 1'b0;
		resetn = 1'b0;
		aw = '0;
		w = '0;
		ar = '0;
		bready = 1'b0;
		rready = 1'b0;
		rng_state = 32'h4a05fb65;
		cycle_limit = 2000;
		ticks = 0;
		cyc = 0;
		moves_accepted = 0;
		moves_cancelled = 0;
		watch = 1'b1;
		prev_drive = 1'b0;
		active = 1'b0;
		last_dir = 1'b0;
		step_k = 0;
		rise_cyc = 0;
		fall_cyc = 0;
		move_end = 0;
		cur = '0;
		repeat (4) @(negedge clk);
		resetn = 1'b1;
		bready = 1'b1;
		rready = 1'b1;

		random_batches(5);

		// engine busy on a long move while four more fill the queue
		cmd = random_move();
		cmd.speed = speed_t'(60);
		cmd.steps = steps_t'(30);
		send_move(cmd, 1'b1);
		for (int i = 0; i < int'(motor_pkg::QUEUE_DEPTH); i++)
			send_move(random_move(), 1'b1);
		send_move(random_move(), 1'b0);
		write_reg(4'h6, 32'h1, resp);
		check_resp("o_b.resp unknown offset", axil_pkg::RESP_SLVERR, resp);
		wait_idle();

		// stop in the middle of a long move with two more queued
		cmd = random_move();
		cmd.speed = speed_t'(150);
		cmd.steps = steps_t'(40);
		send_move(cmd, 1'b1);
		send_move(random_move(), 1'b1);
		send_move(random_move(), 1'b1);
		do
			@(posedge clk);
		while (!(active && step_k >= 5));
		watch = 1'b0;
		write_reg(axil_pkg::REG_CTRL, 32'h1, resp);
		check_resp("o_b.resp ctrl", axil_pkg::RESP_OKAY, resp);
		repeat (2) @(negedge clk);
		if (drive !== 1'b0)
			abort_run("o_drive still high two clocks after the stop");
		@(posedge clk);
		moves_cancelled += expected_moves.size() + 1;
		expected_moves.delete();
		last_dir = cur.dir;
		move_end = cyc;
		active = 1'b0;
		watch = 1'b1;
		check_idle_status();

		random_batches(2);

		$display("TEST PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+test
source/motor_pkg.sv
source/axil_pkg.sv
source/motor_regs.sv
source/cmd_queue.sv
source/speed_profile.sv
source/step_engine.sv
source/motor_top.sv
test/tb_motor_top.sv

// ==== Makefile ====
SIM = obj_dir/Vtb_motor_top
SRCS = $(filter-out +incdir+%,$(shell cat filelist.f))

.PHONY: all run clean

all: $(SIM)

$(SIM): filelist.f $(SRCS) test/tb_motor_model.svh
	verilator --binary --timing --assert -j 0 --top-module tb_motor_top \
		-f filelist.f -o Vtb_motor_top

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
